/* uartCore.f */
uartPkg.sv
baudTickGen.sv
uartRx.sv
uartTx.sv
uartCore.sv
uartCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f uartCore.f \
    --top-module uartCoreTb \
    -o uartCoreSim

simOut=$(./obj_dir/uartCoreSim 2>&1) || true
echo "$simOut"

if grep -q "ALL TESTS PASSED" <<< "$simOut"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* uartCoreTb.sv */
`timescale 1ns/100ps

module uartCoreTb;

    localparam int BIT_CLKS     = uartPkg::OVERSAMPLE * uartPkg::CLKS_PER_TICK;  // clocks per bit
    localparam int WINDOW       = 12 * BIT_CLKS;                // event window of 12 bit times
    localparam int RESET_CYCLES = 16;
    localparam int N_FIXED      = 9;                            // hand picked entries
    localparam int N_RAND       = 4;                            // lcg entries
    localparam int N_ENTRIES    = N_FIXED + N_RAND;
    localparam int CYCLE_LIMIT  = ((N_ENTRIES * WINDOW) + RESET_CYCLES) * 5 / 4;

    // entry kinds
    localparam int KIND_GOOD    = 0;
    localparam int KIND_BAD     = 1;                            // stop bit low
    localparam int KIND_GLITCH  = 2;                            // short low pulse
    localparam int KIND_TX      = 3;
    localparam int KIND_DISABLE = 4;                            // en drop mid frame

    logic             clk = 1'b0;
    logic             reset;
    logic             en;
    logic             rxLine;
    logic             txStart;
    uartPkg::uartByte txData;
    uartPkg::uartByte rxData;
    logic             rxDone;
    logic             rxBusy;
    logic             rxErr;
    logic             txLine;
    logic             txBusy;

    // stimulus table
    int               kindTab    [N_ENTRIES];
    uartPkg::uartByte byteTab    [N_ENTRIES];
    logic             expDoneTab [N_ENTRIES];                   // one rxDone expected
    logic             expErrTab  [N_ENTRIES];                   // rxErr level after entry

    int               cycleCount   = 0;
    int               doneCount    = 0;                         // rxDone pulses seen
    int               errRiseCount = 0;                         // rxErr rising edges
    int               busyCycles   = 0;                         // cycles with rxBusy high
    logic             errLast      = 1'b0;
    logic             midBusy;                                  // rxBusy at data bit 4 middle
    logic             midErr;
    uartPkg::uartByte lastGood     = '0;                        // byte rxData should hold
    logic [31:0]      seed         = 32'h0808_f1d3;

    uartCore uut (
        .clk     (clk),
        .reset   (reset),
        .en      (en),
        .rxLine  (rxLine),
        .txStart (txStart),
        .txData  (txData),
        .rxData  (rxData),
        .rxDone  (rxDone),
        .rxBusy  (rxBusy),
        .rxErr   (rxErr),
        .txLine  (txLine),
        .txBusy  (txBusy)
    );

    always #5 clk = ~clk;                                       // 10 ns period

    // event counters sampled away from the driving edge
    always @(negedge clk) begin
        if (rxDone) doneCount <= doneCount + 1;
        if (rxErr && !errLast) errRiseCount <= errRiseCount + 1;
        if (rxBusy) busyCycles <= busyCycles + 1;
        errLast <= rxErr;
    end

    // run length guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
            failRun();
        end
    end

    task automatic failRun;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic checkByte(input string name, input uartPkg::uartByte expVal,
                             input uartPkg::uartByte actVal);
        if (actVal !== expVal) begin
            $display("error: %s expected 0x%h actual 0x%h", name, expVal, actVal);
            failRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("error: %s expected 0x%h actual 0x%h", name, expVal, actVal);
            failRun();
        end
    endtask

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;                // numerical recipes lcg
    endfunction

    task automatic nextCycle;
        @(posedge clk);
        #1;                                                     // drive just after the edge
    endtask

    task automatic addEntry(input int idx, input int kind, input uartPkg::uartByte data,
                            input logic expDone, input logic expErr);
        kindTab[idx]    = kind;
        byteTab[idx]    = data;
        expDoneTab[idx] = expDone;
        expErrTab[idx]  = expErr;
    endtask

    task automatic buildTable;
        addEntry(0, KIND_GOOD,    8'h55, 1'b1, 1'b0);
        addEntry(1, KIND_GOOD,    8'hA3, 1'b1, 1'b0);
        addEntry(2, KIND_BAD,     8'h3C, 1'b0, 1'b1);
        addEntry(3, KIND_GOOD,    8'h0F, 1'b1, 1'b0);           // clears rxErr
        addEntry(4, KIND_GLITCH,  8'h00, 1'b0, 1'b0);
        addEntry(5, KIND_TX,      8'hC5, 1'b0, 1'b0);
        addEntry(6, KIND_GOOD,    8'h00, 1'b1, 1'b0);
        addEntry(7, KIND_GOOD,    8'hFF, 1'b1, 1'b0);
        addEntry(8, KIND_DISABLE, 8'h96, 1'b1, 1'b0);
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            seed = nextRand(seed);
            // every other random entry is a transmit
            if ((i - N_FIXED) % 2 == 1) addEntry(i, KIND_TX, seed[23:16], 1'b0, 1'b0);
            else addEntry(i, KIND_GOOD, seed[23:16], 1'b1, 1'b0);
        end
    endtask

    // start bit then 8 data bits lsb first then stop bit
    // only the first nBits are driven
    task automatic driveFrame(input uartPkg::uartByte data, input logic stopBit,
                              input int nBits);
        logic [9:0] frame;
        frame = {stopBit, data, 1'b0};
        for (int i = 0; i < nBits; i++) begin
            rxLine = frame[i];
            repeat (BIT_CLKS / 2) nextCycle;
            if (i == 5) begin                                   // middle of data bit 4
                midBusy = rxBusy;
                midErr  = rxErr;
            end
            repeat (BIT_CLKS / 2) nextCycle;
        end
        rxLine = 1'b1;                                          // back to idle
    endtask

    task automatic waitRxEvent(input int startCycle, input int doneBase, input int errBase);
        while (doneCount == doneBase && errRiseCount == errBase) begin
            if (cycleCount - startCycle >= WINDOW) begin
                $display("no rxDone or rxErr came within 12 bit times of the start bit");
                failRun();
            end
            nextCycle;
        end
    endtask

    task automatic receiveFrame(input uartPkg::uartByte data, input logic stopBit,
                                input logic expDone, input logic expErr);
        int startCycle;
        int doneBase;
        int errBase;
        startCycle = cycleCount;
        doneBase   = doneCount;
        errBase    = errRiseCount;
        driveFrame(data, stopBit, 10);
        waitRxEvent(startCycle, doneBase, errBase);
        repeat (BIT_CLKS) nextCycle;                            // idle gap where a stray pulse shows
        if (doneCount - doneBase != int'(expDone)) begin
            $display("byte 0x%h gave %0d rxDone pulses instead of %0d",
                     data, doneCount - doneBase, int'(expDone));
            failRun();
        end
        checkFlag("rxBusy mid frame", 1'b1, midBusy);
        checkFlag("rxErr mid frame", 1'b0, midErr);
        checkFlag("rxErr", expErr, rxErr);
        checkFlag("rxBusy", 1'b0, rxBusy);
        if (expDone) lastGood = data;
        checkByte("rxData", lastGood, rxData);                  // bad frame keeps old byte
    endtask

    task automatic rejectGlitch;
        int doneBase;
        int errBase;
        int busyBase;
        doneBase = doneCount;
        errBase  = errRiseCount;
        busyBase = busyCycles;
        rxLine = 1'b0;
        repeat (4 * uartPkg::CLKS_PER_TICK) nextCycle;          // quarter bit low
        rxLine = 1'b1;
        repeat (WINDOW) nextCycle;
        if (doneCount != doneBase || errRiseCount != errBase || busyCycles != busyBase) begin
            $display("the start glitch caused rxBusy, rxDone or rxErr activity");
            failRun();
        end
    endtask

    task automatic pulseTxStart(input uartPkg::uartByte data);
        txData  = data;
        txStart = 1'b1;
        nextCycle;
        txStart = 1'b0;
    endtask

    // sample txLine in the middle of each bit after the start edge
    task automatic decodeTx(output uartPkg::uartByte data, output logic startBit,
                            output logic stopBit);
        int waited;
        waited = 0;
        while (txLine !== 1'b0) begin
            if (waited >= BIT_CLKS) begin
                $display("txLine never dropped for a start bit");
                failRun();
            end
            nextCycle;
            waited++;
        end
        repeat (BIT_CLKS / 2) nextCycle;
        startBit = txLine;
        for (int i = 0; i < uartPkg::DATA_BITS; i++) begin
            repeat (BIT_CLKS) nextCycle;
            data[i] = txLine;
        end
        repeat (BIT_CLKS) nextCycle;
        stopBit = txLine;
    endtask

    task automatic waitTxIdle;
        int waited;
        waited = 0;
        while (txBusy !== 1'b0) begin
            if (waited >= BIT_CLKS) begin
                $display("txBusy did not fall at the end of the stop bit");
                failRun();
            end
            nextCycle;
            waited++;
        end
    endtask

    task automatic transmitByte(input uartPkg::uartByte data);
        uartPkg::uartByte got;
        logic             startBit;
        logic             stopBit;
        pulseTxStart(data);
        checkFlag("txBusy after txStart", 1'b1, txBusy);
        fork
            decodeTx(got, startBit, stopBit);
            begin
                repeat (3 * BIT_CLKS) nextCycle;
                pulseTxStart(~data);                            // must be ignored
            end
        join
        waitTxIdle();
        checkFlag("tx start bit", 1'b0, startBit);
        checkFlag("tx stop bit", 1'b1, stopBit);
        checkByte("tx data", data, got);
        repeat (BIT_CLKS) nextCycle;
        checkFlag("txBusy after frame", 1'b0, txBusy);          // no second frame queued
        checkFlag("txLine after frame", 1'b1, txLine);
    endtask

    task automatic disableMidFrame(input uartPkg::uartByte data, input logic expDone,
                                   input logic expErr);
        int doneBase;
        pulseTxStart(~data);                                    // keep tx busy too
        doneBase = doneCount;
        driveFrame(data, 1'b1, 6);                              // up to data bit 4
        checkFlag("rxBusy before disable", 1'b1, midBusy);
        checkFlag("txBusy before disable", 1'b1, txBusy);
        en = 1'b0;
        nextCycle;
        checkFlag("rxBusy after disable", 1'b0, rxBusy);
        checkFlag("txBusy after disable", 1'b0, txBusy);
        checkFlag("txLine after disable", 1'b1, txLine);
        repeat (WINDOW) nextCycle;                              // long enough for the cut frame to end
        if (doneCount != doneBase) begin
            $display("rxDone appeared for a frame cut off by en");
            failRun();
        end
        en = 1'b1;
        receiveFrame(data, 1'b1, expDone, expErr);              // full frame after re-enable
    endtask

    initial begin
        reset   = 1'b1;
        en      = 1'b1;
        rxLine  = 1'b1;
        txStart = 1'b0;
        txData  = '0;
        buildTable();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values
        checkFlag("rxDone", 1'b0, rxDone);
        checkFlag("rxBusy", 1'b0, rxBusy);
        checkFlag("rxErr", 1'b0, rxErr);
        checkFlag("txBusy", 1'b0, txBusy);
        checkFlag("txLine", 1'b1, txLine);
        checkByte("rxData", 8'h00, rxData);

        for (int i = 0; i < N_ENTRIES; i++) begin
            case (kindTab[i])
                KIND_GOOD:    receiveFrame(byteTab[i], 1'b1, expDoneTab[i], expErrTab[i]);
                KIND_BAD:     receiveFrame(byteTab[i], 1'b0, expDoneTab[i], expErrTab[i]);
                KIND_GLITCH:  rejectGlitch();
                KIND_TX:      transmitByte(byteTab[i]);
                KIND_DISABLE: disableMidFrame(byteTab[i], expDoneTab[i], expErrTab[i]);
                default: begin
                    $display("table entry %0d has an unknown kind", i);
                    failRun();
                end
            endcase
            $display("entry %0d kind %0d byte 0x%h ok", i, kindTab[i], byteTab[i]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* uartCore.sv */
`timescale 1ns/100ps

module uartCore (
    input  logic             clk,        // system clock
    input  logic             reset,      // sync, active high
    input  logic             en,         // enable for all blocks
    input  logic             rxLine,     // serial in
    input  logic             txStart,    // send strobe
    input  uartPkg::uartByte txData,     // byte to send
    output uartPkg::uartByte rxData,     // received byte
    output logic             rxDone,     // byte strobe
    output logic             rxBusy,     // receive in progress
    output logic             rxErr,      // framing error
    output logic             txLine,     // serial out
    output logic             txBusy      // transmit in progress
);

    logic tick;                          // shared 16x baud strobe

    baudTickGen tickGen (
        .clk   (clk),
        .reset (reset),
        .en    (en),
        .tick  (tick)
    );

    // receive path
    uartRx rx (
        .clk    (clk),
        .reset  (reset),
        .en     (en),
        .tick   (tick),
        .rxLine (rxLine),
        .rxData (rxData),
        .rxDone (rxDone),
        .rxBusy (rxBusy),
        .rxErr  (rxErr)
    );

    // transmit path
    uartTx tx (
        .clk     (clk),
        .reset   (reset),
        .en      (en),
        .tick    (tick),
        .txStart (txStart),
        .txData  (txData),
        .txLine  (txLine),
        .txBusy  (txBusy)
    );

endmodule

/* uartTx.sv */
`timescale 1ns/100ps

module uartTx (
    input  logic             clk,        // system clock
    input  logic             reset,      // sync, active high
    input  logic             en,         // core enable
    input  logic             tick,       // 16x oversample strobe
    input  logic             txStart,    // send request strobe
    input  uartPkg::uartByte txData,     // byte to send
    output logic             txLine,     // serial output, idles high
    output logic             txBusy      // frame pending or in progress
);

    uartPkg::txState   state;
    uartPkg::tickCount tickCnt;          // ticks inside current bit
    uartPkg::bitIndex  bitIdx;           // data bit on the line
    uartPkg::uartByte  txShift;          // bit 0 is on the line in TX_DATA
    logic              accept;           // start taken this cycle
    logic              bitEnd;           // last tick of current bit

    assign accept = en && txStart && !txBusy;
    assign bitEnd = tick && (tickCnt == uartPkg::BIT_LAST);

    // byte capture and shifting
    always_ff @(posedge clk) begin
        if (accept) begin
            txShift <= txData;
        end else if (state == uartPkg::TX_DATA && bitEnd) begin
            txShift <= txShift >> 1;                     // next bit to bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !en) begin
            state   <= uartPkg::TX_IDLE;
            tickCnt <= '0;
            bitIdx  <= '0;
            txLine  <= 1'b1;                             // mark level
            txBusy  <= 1'b0;
        end else begin
            case (state)
                uartPkg::TX_IDLE: begin
                    if (accept) begin
                        txBusy <= 1'b1;                  // launch waits for next tick
                    end else if (txBusy && tick) begin
                        txLine  <= 1'b0;                 // start bit begins
                        tickCnt <= '0;
                        state   <= uartPkg::TX_START;
                    end
                end

                uartPkg::TX_START: begin
                    if (bitEnd) begin
                        tickCnt <= '0;
                        bitIdx  <= '0;
                        txLine  <= txShift[0];           // lsb first
                        state   <= uartPkg::TX_DATA;
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end

                uartPkg::TX_DATA: begin
                    if (bitEnd) begin
                        tickCnt <= '0;
                        if (bitIdx == uartPkg::LAST_BIT) begin
                            txLine <= 1'b1;              // stop bit
                            state  <= uartPkg::TX_STOP;
                        end else begin
                            txLine <= txShift[1];        // bit shifting into place
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end

                uartPkg::TX_STOP: begin
                    if (bitEnd) begin
                        tickCnt <= '0;
                        txBusy  <= 1'b0;                 // full stop bit sent
                        state   <= uartPkg::TX_IDLE;
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end

                default: state <= uartPkg::TX_IDLE;
            endcase
        end
    end

endmodule

/* uartRx.sv */
`timescale 1ns/100ps

module uartRx (
    input  logic             clk,        // system clock
    input  logic             reset,      // sync, active high
    input  logic             en,         // core enable
    input  logic             tick,       // 16x oversample strobe
    input  logic             rxLine,     // async serial input
    output uartPkg::uartByte rxData,     // last good byte
    output logic             rxDone,     // one-cycle byte strobe
    output logic             rxBusy,     // frame in progress
    output logic             rxErr       // framing error level
);

    logic [1:0]        syncReg;          // two-flop synchronizer
    logic              rxIn;             // synchronized line
    uartPkg::rxState   state;
    uartPkg::tickCount tickCnt;          // ticks inside current bit
    uartPkg::bitIndex  bitIdx;           // data bit being received
    uartPkg::uartByte  shiftReg;         // assembles lsb first
    logic              stopLow;          // bad stop seen, wait for idle line
    logic              midBit;           // tick at middle of a data or stop bit
    logic              sampleData;       // take one data bit now
    logic              stopOk;           // stop bit high at its middle

    assign rxIn       = syncReg[1];
    assign midBit     = tick && (tickCnt == uartPkg::BIT_LAST);
    assign sampleData = (state == uartPkg::RX_DATA) && midBit;
    assign stopOk     = en && (state == uartPkg::RX_STOP) && !stopLow && midBit && rxIn;

    // idle level out of reset so no false start is seen
    always_ff @(posedge clk) begin
        if (reset) begin
            syncReg <= 2'b11;
        end else begin
            syncReg <= {syncReg[0], rxLine};
        end
    end

    // receive FSM, everything counts on tick
    always_ff @(posedge clk) begin
        if (reset || !en) begin
            state   <= uartPkg::RX_IDLE;
            tickCnt <= '0;
            bitIdx  <= '0;
            stopLow <= 1'b0;
            rxDone  <= 1'b0;
            rxBusy  <= 1'b0;
            rxErr   <= 1'b0;
        end else begin
            rxDone <= 1'b0;                              // pulse by default
            case (state)
                uartPkg::RX_IDLE: begin
                    if (tick && !rxIn) begin             // possible start edge
                        state   <= uartPkg::RX_START;
                        tickCnt <= '0;
                    end
                end

                uartPkg::RX_START: begin
                    if (tick) begin
                        if (tickCnt == uartPkg::HALF_LAST) begin
                            tickCnt <= '0;
                            if (!rxIn) begin             // still low, real start
                                state  <= uartPkg::RX_DATA;
                                bitIdx <= '0;
                                rxBusy <= 1'b1;
                                rxErr  <= 1'b0;          // new frame clears old error
                            end else begin
                                state <= uartPkg::RX_IDLE; // glitch, drop it
                            end
                        end else begin
                            tickCnt <= tickCnt + 1'b1;
                        end
                    end
                end

                uartPkg::RX_DATA: begin
                    if (midBit) begin
                        tickCnt <= '0;
                        if (bitIdx == uartPkg::LAST_BIT) begin
                            state <= uartPkg::RX_STOP;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end

                uartPkg::RX_STOP: begin
                    if (stopLow) begin
                        if (rxIn) begin                  // line back high
                            stopLow <= 1'b0;
                            state   <= uartPkg::RX_IDLE;
                        end
                    end else if (midBit) begin
                        tickCnt <= '0;
                        rxBusy  <= 1'b0;
                        if (rxIn) begin
                            rxDone <= 1'b1;              // byte goes out with rxData
                            state  <= uartPkg::RX_IDLE;
                        end else begin
                            rxErr   <= 1'b1;             // framing error
                            stopLow <= 1'b1;
                        end
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end

                default: state <= uartPkg::RX_IDLE;
            endcase
        end
    end

    // data shift register
    always_ff @(posedge clk) begin
        if (sampleData) begin
            shiftReg <= {rxIn, shiftReg[uartPkg::DATA_BITS-1:1]};  // lsb arrives first
        end
    end

    // output byte only changes on a good stop
    always_ff @(posedge clk) begin
        if (reset) begin
            rxData <= '0;
        end else if (stopOk) begin
            rxData <= shiftReg;                          // same cycle as rxDone
        end
    end

endmodule

/* baudTickGen.sv */
`timescale 1ns/100ps

module baudTickGen (
    input  logic clk,                    // system clock
    input  logic reset,                  // sync, active high
    input  logic en,                     // core enable
    output logic tick                    // one-cycle oversample strobe
);

    uartPkg::divCount divCnt;            // clocks since last tick
    logic             wrap;              // divider at terminal count

    assign wrap = (divCnt == uartPkg::TICK_LAST);

    // free running divider, parked at zero while disabled
    always_ff @(posedge clk) begin
        if (reset || !en) begin
            divCnt <= '0;
        end else if (wrap) begin
            divCnt <= '0;                // restart period
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // registered strobe, first one CLKS_PER_TICK clocks after release
    always_ff @(posedge clk) begin
        if (reset || !en) begin
            tick <= 1'b0;
        end else begin
            tick <= wrap;                // one clock wide
        end
    end

endmodule

/* uartPkg.sv */
package uartPkg;

    // frame and timing
    localparam int CLKS_PER_TICK = 4;              // sim value, one bit = 64 clocks
    localparam int OVERSAMPLE    = 16;             // ticks per bit
    localparam int HALF_BIT      = 8;              // start bit mid-point in ticks
    localparam int DATA_BITS     = 8;              // data bits per frame

    // derived widths
    localparam int DIV_W  = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam int TICK_W = $clog2(OVERSAMPLE);    // 4 bits for 16x
    localparam int IDX_W  = $clog2(DATA_BITS);     // 3 bits for 8 data bits

    typedef logic [DATA_BITS-1:0] uartByte;        // one data byte
    typedef logic [TICK_W-1:0]    tickCount;       // ticks inside one bit
    typedef logic [IDX_W-1:0]     bitIndex;        // data bit position
    typedef logic [DIV_W-1:0]     divCount;        // clocks inside one tick

    // terminal counts
    localparam divCount  TICK_LAST = divCount'(CLKS_PER_TICK - 1);   // divider wrap
    localparam tickCount BIT_LAST  = tickCount'(OVERSAMPLE - 1);     // last tick of a bit
    localparam tickCount HALF_LAST = tickCount'(HALF_BIT - 1);       // start check tick
    localparam bitIndex  LAST_BIT  = bitIndex'(DATA_BITS - 1);       // msb index

    // receiver states
    typedef enum logic [1:0] {
        RX_IDLE,                                   // line idle, look for low sample
        RX_START,                                  // validating start bit
        RX_DATA,                                   // shifting in data bits
        RX_STOP                                    // checking stop bit
    } rxState;

    // transmitter states
    typedef enum logic [1:0] {
        TX_IDLE,                                   // idle or waiting to launch
        TX_START,                                  // driving start bit
        TX_DATA,                                   // driving data bits
        TX_STOP                                    // driving stop bit
    } txState;

endpackage
